// ==== compile.f ====
+incdir+.
geometry_pkg.sv
color_pkg.sv
column_capture.sv
row_scanner.sv
pixel_writer.sv
column_flattener.sv
tb_column_flattener.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the column flattener testbench with verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f \
    --top-module tb_column_flattener

# keep the output even when the simulation exits with an error
output=$(./obj_dir/Vtb_column_flattener) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qF '*** TEST PASSED ***'; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// ==== tb_column_model.svh ====
`ifndef TB_COLUMN_MODEL_SVH
`define TB_COLUMN_MODEL_SVH

// first wall row, half the line height above the horizon
function automatic int draw_start_for(input int line_height);
    int start;
    start = half_screen_height - line_height / 2;
    if (start < 0)
        start = 0;   // tall walls reach the top row
    return start;
endfunction

// first floor row, never past the bottom of the screen
function automatic int draw_end_for(input int line_height);
    int stop;
    stop = half_screen_height + line_height / 2;
    if (stop > screen_height)
        stop = screen_height;
    return stop;
endfunction

// expected pixel word, shade bit on top of the palette colour
function automatic logic [8:0] pixel_for(input int row, input int line_height,
                                         input int map, input logic wall_type);
    logic [7:0] color;
    logic       shade;
    shade = 1'b0;
    if (row < draw_start_for(line_height)) begin
        color = sky_color;
    end else if (row >= draw_end_for(line_height)) begin
        color = ground_color;
    end else begin
        case (map)
            0:       color = sky_color;
            2:       color = green_wall_color;
            default: color = black_wall_color;   // 1 and every textured cell
        endcase
        shade = (map != 0) ? wall_type : 1'b0;   // empty cell never darkened
    end
    return {shade, color};
endfunction

// row major frame buffer address
function automatic logic [15:0] frame_addr(input int hcount, input int vcount);
    return 16'(hcount + vcount * screen_width);
endfunction

`endif

// ==== tb_column_flattener.sv ====
`timescale 1ns/10ps

module tb_column_flattener
    import geometry_pkg::*;
    import color_pkg::*;
();

    localparam int cycle_limit = 6000;   // about 3400 cycles of tests plus margin

    logic        pixel_clk_in = 1'b0;
    logic        rst_in       = 1'b1;
    logic        dda_fifo_tvalid_in;
    dda_word_t   dda_fifo_tdata_in;
    logic        dda_fifo_tlast_in;
    logic [1:0]  fb_ready_to_switch_in;
    logic        transformer_tready_out;
    logic        pixel_valid_out;
    pixel_addr_t ray_address_out;
    ray_pixel_t  ray_pixel_out;
    logic        ray_last_pixel_out;

    int cycle_cnt    = 0;   // rising edges seen so far
    int error_cnt    = 0;
    int pixel_cnt    = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int seed;

    // pixels the dut still owes with the oldest at the front
    logic [15:0] q_addr[$];
    logic [8:0]  q_pixel[$];
    logic        q_last[$];
    int          q_cycle[$];   // edge count at which each pixel shows

    `include "tb_column_model.svh"

    column_flattener dut0 (
        .pixel_clk_in           (pixel_clk_in),
        .rst_in                 (rst_in),
        .dda_fifo_tvalid_in     (dda_fifo_tvalid_in),
        .dda_fifo_tdata_in      (dda_fifo_tdata_in),
        .dda_fifo_tlast_in      (dda_fifo_tlast_in),
        .fb_ready_to_switch_in  (fb_ready_to_switch_in),
        .transformer_tready_out (transformer_tready_out),
        .pixel_valid_out        (pixel_valid_out),
        .ray_address_out        (ray_address_out),
        .ray_pixel_out          (ray_pixel_out),
        .ray_last_pixel_out     (ray_last_pixel_out)
    );

    always #50 pixel_clk_in = ~pixel_clk_in;   // 100 ns period

    always @(posedge pixel_clk_in) cycle_cnt <= cycle_cnt + 1;

    task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        if (got !== want) begin
            $display("Error at %0d ns: %s is %0h, expected %0h", $time, what, got, want);
            error_cnt++;
        end
    endtask

    // output monitor sampled mid cycle
    always @(negedge pixel_clk_in) begin
        if (rst_in == 1'b0) begin
            if (pixel_valid_out) begin
                pixel_cnt++;
                if (q_addr.size() == 0) begin
                    $display("pixel strobe at %0d ns with no column outstanding", $time);
                    error_cnt++;
                end else begin
                    check_value(ray_address_out, q_addr.pop_front(), "pixel address");
                    check_value(ray_pixel_out, q_pixel.pop_front(), "pixel value");
                    check_value(ray_last_pixel_out, q_last.pop_front(), "last pixel flag");
                    check_value(cycle_cnt, q_cycle.pop_front(), "pixel cycle");
                end
            end else begin
                check_value(ray_last_pixel_out, 1'b0, "last flag outside a strobe");
            end
        end
    end

    always @(negedge pixel_clk_in) begin
        if (cycle_cnt >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycle_cnt);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // word fields from the msb down to the wallx bits the dut ignores
    function automatic dda_word_t make_word(input int hcount, input int line_height,
                                            input logic wall_type, input int map,
                                            input int wallx);
        return {hcount[8:0], line_height[7:0], wall_type, map[3:0], wallx[15:0]};
    endfunction

    task automatic present_column(input int h, input int lh, input logic wt,
                                  input int map, input logic last);
        dda_fifo_tvalid_in = 1'b1;   // held until the handshake
        dda_fifo_tdata_in  = make_word(h, lh, wt, map, $random(seed));
        dda_fifo_tlast_in  = last;
    endtask

    // wait for the handshake and log the 180 pixels the column owes
    task automatic await_accept(input int h, input int lh, input logic wt, input int map,
                                input logic last, output int acc_edge);
        logic taken;
        int   r;
        taken = 1'b0;
        while (!taken) begin
            @(negedge pixel_clk_in);
            if (q_addr.size() >= 3)   // scanner still walking a column
                check_value(transformer_tready_out, 1'b0, "ready while a column is busy");
            taken = transformer_tready_out;
        end
        acc_edge = cycle_cnt + 1;   // taken at the coming edge
        for (r = 0; r < screen_height; r++) begin
            q_addr.push_back(frame_addr(h, r));
            q_pixel.push_back(pixel_for(r, lh, map, wt));
            q_last.push_back(last && (r == screen_height - 1));
            q_cycle.push_back(acc_edge + 2 + r);   // capture then scan then write
        end
        @(posedge pixel_clk_in);
        #1;
    endtask

    task automatic send_column(input int h, input int lh, input logic wt, input int map,
                               input logic last, output int acc_edge);
        present_column(h, lh, wt, map, last);
        await_accept(h, lh, wt, map, last, acc_edge);
    endtask

    task automatic wait_drain();
        while (q_addr.size() != 0)
            @(negedge pixel_clk_in);
        repeat (3) @(negedge pixel_clk_in);   // room for stray strobes
        @(posedge pixel_clk_in);
        #1;
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_cnt == errors_before) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, error_cnt - errors_before);
        end
    endtask

    task automatic test_reset_state();
        int errs;
        errs = error_cnt;
        @(negedge pixel_clk_in);
        check_value(transformer_tready_out, 1'b1, "ready after reset");
        check_value(pixel_valid_out, 1'b0, "pixel strobe after reset");
        check_value(ray_last_pixel_out, 1'b0, "last flag after reset");
        @(posedge pixel_clk_in);
        #1;
        report_test("reset state", errs);
    endtask

    // line height over the screen so every row clamps to wall
    task automatic test_single_column();
        int errs;
        int count0;
        int acc;
        errs   = error_cnt;
        count0 = pixel_cnt;
        send_column(37, 201, 1'b1, 2, 1'b0, acc);
        dda_fifo_tvalid_in = 1'b0;
        wait_drain();
        check_value(pixel_cnt - count0, screen_height, "pixels in one column");
        report_test("single column", errs);
    endtask

    task automatic test_shading();
        int maps[4] = '{0, 1, 2, 7};
        int errs;
        int count0;
        int acc;
        int i;
        int wt;
        errs   = error_cnt;
        count0 = pixel_cnt;
        for (i = 0; i < 4; i++) begin
            for (wt = 0; wt < 2; wt++) begin
                send_column(10 + i * 40 + wt, 50 + i * 30 + wt * 11, wt[0], maps[i], 1'b0, acc);
            end
        end
        dda_fifo_tvalid_in = 1'b0;
        wait_drain();
        check_value(pixel_cnt - count0, 8 * screen_height, "pixels over the shading set");
        report_test("shading and palette", errs);
    endtask

    task automatic test_frame_end();
        int errs;
        int acc;
        int fb_cycle;
        errs = error_cnt;
        fb_ready_to_switch_in = 2'b01;   // one buffer not ready yet
        send_column(319, 120, 1'b1, 1, 1'b1, acc);
        present_column(5, 64, 1'b0, 2, 1'b0);   // next frame waits on the bus
        wait_drain();
        repeat (20) begin
            @(negedge pixel_clk_in);
            check_value(transformer_tready_out, 1'b0, "ready before buffers swap");
        end
        @(posedge pixel_clk_in);
        #1;
        fb_ready_to_switch_in = 2'b11;
        fb_cycle = cycle_cnt;
        await_accept(5, 64, 1'b0, 2, 1'b0, acc);
        check_value(acc, fb_cycle + 2, "accept edge after swap");   // ready one cycle late
        dda_fifo_tvalid_in = 1'b0;
        wait_drain();
        report_test("frame end", errs);
    endtask

    task automatic test_random_stream();
        logic [31:0] rnd;
        int          errs;
        int          count0;
        int          acc;
        int          i;
        errs   = error_cnt;
        count0 = pixel_cnt;
        for (i = 0; i < 8; i++) begin
            rnd = $random(seed);
            send_column(int'(rnd[8:0]) % screen_width, int'(rnd[16:9]), rnd[17],
                        int'(rnd[21:18]), 1'b0, acc);   // tvalid stays high
        end
        dda_fifo_tvalid_in = 1'b0;
        wait_drain();
        check_value(pixel_cnt - count0, 8 * screen_height, "pixels over the random stream");
        report_test("random stream", errs);
    endtask

    initial begin
        seed                  = 32'h61a2_a984;
        dda_fifo_tvalid_in    = 1'b0;
        dda_fifo_tdata_in     = '0;
        dda_fifo_tlast_in     = 1'b0;
        fb_ready_to_switch_in = 2'b11;
        repeat (8) @(posedge pixel_clk_in);
        #1;
        rst_in = 1'b0;
        test_reset_state();
        test_single_column();
        test_shading();
        test_frame_end();
        test_random_stream();
        $display("tests passed %0d, failed %0d, check errors %0d",
                 tests_passed, tests_failed, error_cnt);
        if (tests_failed == 0 && error_cnt == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== column_flattener.sv ====
`timescale 1ns/10ps

module column_flattener
    import geometry_pkg::*;
    import color_pkg::*;
(
    input  logic        pixel_clk_in,
    input  logic        rst_in,
    input  logic        dda_fifo_tvalid_in,
    input  dda_word_t   dda_fifo_tdata_in,
    input  logic        dda_fifo_tlast_in,
    input  logic [1:0]  fb_ready_to_switch_in,
    output logic        transformer_tready_out,
    output logic        pixel_valid_out,
    output pixel_addr_t ray_address_out,
    output ray_pixel_t  ray_pixel_out,
    output logic        ray_last_pixel_out
);

    // capture -> scanner
    logic        col_start;
    hcount_t     col_hcount;
    vcount_t     col_draw_start;
    vcount_t     col_draw_end;
    map_cell_t   col_map;
    logic        col_wall_type;
    logic        col_last;
    logic        col_done;   // scanner -> capture

    // scanner -> writer
    logic        row_valid;
    hcount_t     row_hcount;
    vcount_t     row_vcount;
    row_region_t row_region;
    map_cell_t   row_map;
    logic        row_wall_type;
    logic        row_last_row;

    column_capture capture0 (
        .pixel_clk_in           (pixel_clk_in),
        .rst_in                 (rst_in),
        .dda_fifo_tvalid_in     (dda_fifo_tvalid_in),
        .dda_fifo_tdata_in      (dda_fifo_tdata_in),
        .dda_fifo_tlast_in      (dda_fifo_tlast_in),
        .fb_ready_to_switch_in  (fb_ready_to_switch_in),
        .col_done               (col_done),
        .transformer_tready_out (transformer_tready_out),
        .col_start              (col_start),
        .col_hcount             (col_hcount),
        .col_draw_start         (col_draw_start),
        .col_draw_end           (col_draw_end),
        .col_map                (col_map),
        .col_wall_type          (col_wall_type),
        .col_last               (col_last)
    );

    row_scanner scanner0 (
        .pixel_clk_in   (pixel_clk_in),
        .rst_in         (rst_in),
        .col_start      (col_start),
        .col_hcount     (col_hcount),
        .col_draw_start (col_draw_start),
        .col_draw_end   (col_draw_end),
        .col_map        (col_map),
        .col_wall_type  (col_wall_type),
        .col_last       (col_last),
        .col_done       (col_done),
        .row_valid      (row_valid),
        .row_hcount     (row_hcount),
        .row_vcount     (row_vcount),
        .row_region     (row_region),
        .row_map        (row_map),
        .row_wall_type  (row_wall_type),
        .row_last_row   (row_last_row)
    );

    pixel_writer writer0 (
        .pixel_clk_in       (pixel_clk_in),
        .rst_in             (rst_in),
        .row_valid          (row_valid),
        .row_hcount         (row_hcount),
        .row_vcount         (row_vcount),
        .row_region         (row_region),
        .row_map            (row_map),
        .row_wall_type      (row_wall_type),
        .row_last_row       (row_last_row),
        .pixel_valid_out    (pixel_valid_out),
        .ray_address_out    (ray_address_out),
        .ray_pixel_out      (ray_pixel_out),
        .ray_last_pixel_out (ray_last_pixel_out)
    );

endmodule

// ==== pixel_writer.sv ====
`timescale 1ns/10ps

module pixel_writer
    import geometry_pkg::*;
    import color_pkg::*;
(
    input  logic        pixel_clk_in,
    input  logic        rst_in,
    input  logic        row_valid,
    input  hcount_t     row_hcount,
    input  vcount_t     row_vcount,
    input  row_region_t row_region,
    input  map_cell_t   row_map,
    input  logic        row_wall_type,
    input  logic        row_last_row,
    output logic        pixel_valid_out,      // no back-pressure, fb takes every strobe
    output pixel_addr_t ray_address_out,
    output ray_pixel_t  ray_pixel_out,
    output logic        ray_last_pixel_out
);

    color_t      color_next;
    logic        shade_next;
    pixel_addr_t addr_next;

    // palette and shading
    always_comb begin
        color_next = sky_color;
        shade_next = 1'b0;   // ceiling and floor stay unshaded
        case (row_region)
            region_ceiling: color_next = sky_color;
            region_floor:   color_next = ground_color;
            region_wall: begin
                shade_next = row_wall_type;   // y side hits darker
                case (row_map)
                    4'd0: begin
                        color_next = sky_color;   // empty cell, no shade
                        shade_next = 1'b0;
                    end
                    4'd1:    color_next = black_wall_color;
                    4'd2:    color_next = green_wall_color;
                    default: color_next = black_wall_color;   // old texture cells
                endcase
            end
            default: color_next = sky_color;
        endcase
    end

    // flat address, constant multiply by the row pitch
    assign addr_next = pixel_addr_t'(row_hcount)
                     + pixel_addr_t'(row_vcount) * pixel_addr_t'(screen_width);

    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            pixel_valid_out    <= 1'b0;
            ray_last_pixel_out <= 1'b0;
        end else begin
            pixel_valid_out    <= row_valid;
            ray_last_pixel_out <= row_valid && row_last_row;
        end
    end

    always_ff @(posedge pixel_clk_in) begin
        if (row_valid) begin
            ray_address_out <= addr_next;
            ray_pixel_out   <= {shade_next, color_next};
        end
    end

    addr_in_frame: assert property (
        @(posedge pixel_clk_in) disable iff (rst_in)
        pixel_valid_out |-> (ray_address_out < pixel_addr_t'(screen_width * screen_height))
    );

endmodule

// ==== row_scanner.sv ====
`timescale 1ns/10ps

module row_scanner import geometry_pkg::*; (
    input  logic        pixel_clk_in,
    input  logic        rst_in,
    input  logic        col_start,
    input  hcount_t     col_hcount,
    input  vcount_t     col_draw_start,
    input  vcount_t     col_draw_end,
    input  map_cell_t   col_map,
    input  logic        col_wall_type,
    input  logic        col_last,
    output logic        col_done,       // high with row 179
    output logic        row_valid,
    output hcount_t     row_hcount,
    output vcount_t     row_vcount,
    output row_region_t row_region,
    output map_cell_t   row_map,
    output logic        row_wall_type,
    output logic        row_last_row    // row 179 of the frame's last column
);

    logic    active;      // walking a column
    vcount_t row_cnt;
    logic    final_row;

    // local copy of the column, capture side may reload after col_done
    hcount_t   scan_hcount;
    vcount_t   scan_draw_start;
    vcount_t   scan_draw_end;
    map_cell_t scan_map;
    logic      scan_wall_type;
    logic      scan_last;

    assign final_row = (row_cnt == vcount_t'(screen_height - 1));

    // row counter, one row per cycle with no gaps
    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            active  <= 1'b0;
            row_cnt <= '0;
        end else if (col_start) begin
            active  <= 1'b1;
            row_cnt <= '0;
        end else if (active) begin
            if (final_row) begin
                active  <= 1'b0;   // column finished
                row_cnt <= '0;
            end else begin
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge pixel_clk_in) begin
        if (col_start) begin
            scan_hcount     <= col_hcount;
            scan_draw_start <= col_draw_start;
            scan_draw_end   <= col_draw_end;
            scan_map        <= col_map;
            scan_wall_type  <= col_wall_type;
            scan_last       <= col_last;
        end
    end

    // classify the current row against the column bounds
    always_comb begin
        if (row_cnt < scan_draw_start) begin
            row_region = region_ceiling;
        end else if (row_cnt >= scan_draw_end) begin
            row_region = region_floor;
        end else begin
            row_region = region_wall;
        end
    end

    assign row_valid     = active;
    assign row_vcount    = row_cnt;
    assign row_hcount    = scan_hcount;
    assign row_map       = scan_map;
    assign row_wall_type = scan_wall_type;
    assign col_done      = active && final_row;
    assign row_last_row  = active && final_row && scan_last;

    // the counter wraps before leaving the screen
    row_in_screen: assert property (
        @(posedge pixel_clk_in) disable iff (rst_in)
        row_valid |-> (row_vcount < vcount_t'(screen_height))
    );

endmodule

// ==== column_capture.sv ====
`timescale 1ns/10ps

module column_capture import geometry_pkg::*; (
    input  logic       pixel_clk_in,
    input  logic       rst_in,
    input  logic       dda_fifo_tvalid_in,
    input  dda_word_t  dda_fifo_tdata_in,
    input  logic       dda_fifo_tlast_in,
    input  logic [1:0] fb_ready_to_switch_in,   // one bit per frame buffer
    input  logic       col_done,                // scanner on its final row
    output logic       transformer_tready_out,
    output logic       col_start,               // one cycle, fields valid with it
    output hcount_t    col_hcount,
    output vcount_t    col_draw_start,
    output vcount_t    col_draw_end,
    output map_cell_t  col_map,
    output logic       col_wall_type,
    output logic       col_last
);

    typedef enum logic [1:0] {
        capture_wait_column,   // ready high, waiting for a fifo word
        capture_busy,          // column handed to scanner
        capture_wait_frame     // frame done, waiting for both buffers
    } capture_state_t;

    capture_state_t state;

    logic         accept;          // fifo handshake this edge
    logic         fb_both_ready;
    line_height_t line_height;
    vcount_t      half_height;
    vcount_t      draw_start_next;
    vcount_t      draw_end_next;

    assign accept        = dda_fifo_tvalid_in && transformer_tready_out;
    assign fb_both_ready = &fb_ready_to_switch_in;

    assign line_height = dda_fifo_tdata_in[line_height_msb:line_height_lsb];
    assign half_height = line_height >> 1;

    // clamp bounds to the screen, tall walls cover every row
    always_comb begin
        if (half_height >= vcount_t'(half_screen_height)) begin
            draw_start_next = '0;
            draw_end_next   = vcount_t'(screen_height);
        end else begin
            draw_start_next = vcount_t'(half_screen_height) - half_height;
            draw_end_next   = vcount_t'(half_screen_height) + half_height;   // max 179
        end
    end

    // control
    always_ff @(posedge pixel_clk_in) begin
        if (rst_in) begin
            state                  <= capture_wait_column;
            transformer_tready_out <= 1'b1;
            col_start              <= 1'b0;
        end else begin
            col_start <= accept;   // strobe one cycle after the handshake
            case (state)
                capture_wait_column: begin
                    if (accept) begin
                        transformer_tready_out <= 1'b0;
                        state                  <= capture_busy;
                    end
                end
                capture_busy: begin
                    if (col_done) begin
                        if (!col_last || fb_both_ready) begin
                            transformer_tready_out <= 1'b1;   // next column right away
                            state                  <= capture_wait_column;
                        end else begin
                            state <= capture_wait_frame;   // hold off until buffers swap
                        end
                    end
                end
                capture_wait_frame: begin
                    if (fb_both_ready) begin
                        transformer_tready_out <= 1'b1;
                        state                  <= capture_wait_column;
                    end
                end
                default: begin
                    transformer_tready_out <= 1'b1;
                    state                  <= capture_wait_column;
                end
            endcase
        end
    end

    // column fields, held until the next accepted word
    always_ff @(posedge pixel_clk_in) begin
        if (accept) begin
            col_hcount     <= dda_fifo_tdata_in[hcount_msb:hcount_lsb];
            col_draw_start <= draw_start_next;
            col_draw_end   <= draw_end_next;
            col_map        <= dda_fifo_tdata_in[map_msb:map_lsb];
            col_wall_type  <= dda_fifo_tdata_in[wall_type_bit];
            col_last       <= dda_fifo_tlast_in;   // last column of the frame
        end
    end

    // no new word may be taken while a column is being scanned
    ready_low_while_busy: assert property (
        @(posedge pixel_clk_in) disable iff (rst_in)
        (state == capture_busy) |-> !transformer_tready_out
    );

endmodule

// ==== color_pkg.sv ====
package color_pkg;

    // 8 bit palette index into the frame buffer colour map
    typedef logic [7:0] color_t;

    // frame buffer pixel word
    // bit 8 is the shade bit, set for y side wall hits
    // bits 7..0 are the palette colour
    typedef logic [8:0] ray_pixel_t;

    // palette
    localparam color_t sky_color        = 8'h2a;   // sky blue
    localparam color_t ground_color     = 8'hdc;   // brown floor
    localparam color_t black_wall_color = 8'hff;
    localparam color_t green_wall_color = 8'h97;

    // map cell mapping for wall rows:
    //   0      -> sky, never shaded
    //   1      -> black wall
    //   2      -> green wall
    //   3..15  -> black wall (textured cells fall back to black)
    //
    // ceiling and floor rows ignore the map and are never shaded

endpackage

// ==== geometry_pkg.sv ====
package geometry_pkg;

    // visible frame, one pixel per row per column
    localparam int screen_width       = 320;
    localparam int screen_height      = 180;
    localparam int half_screen_height = screen_height / 2;   // horizon row

    // dda fifo word layout
    localparam int dda_word_width  = 38;
    localparam int hcount_msb      = 37;
    localparam int hcount_lsb      = 29;
    localparam int line_height_msb = 28;
    localparam int line_height_lsb = 21;
    localparam int wall_type_bit   = 20;   // 0 = x side hit, 1 = y side hit
    localparam int map_msb         = 19;
    localparam int map_lsb         = 16;
    // bits 15..0 hold wallx, unused here

    // one fifo word per screen column
    typedef logic [dda_word_width-1:0] dda_word_t;

    // column index, 0..319
    typedef logic [8:0] hcount_t;

    // row index, 0..179
    typedef logic [7:0] vcount_t;

    // projected wall height in rows, may exceed the screen
    typedef logic [7:0] line_height_t;

    // map cell value from the dda
    typedef logic [3:0] map_cell_t;

    // flat frame buffer address, h + v*320
    typedef logic [15:0] pixel_addr_t;

    // what a row of the current column shows
    typedef enum logic [1:0] {
        region_ceiling,   // above draw_start
        region_floor,     // at or below draw_end
        region_wall       // between the bounds
    } row_region_t;

endpackage
